// File: common/ocl_pkg.sv
// Slot map, fixed data words, slow-slot timing and the OCL address overlay

package ocl_pkg;

  // ------------------------------
  // Slot map
  // ------------------------------
  localparam int unsigned OCL_NUM_SLOTS = 16;

  localparam logic [3:0] OCL_SLOT_SCRATCH = 4'd0;
  localparam logic [3:0] OCL_SLOT_SLOW    = 4'd5;

  // ------------------------------
  // Fixed words
  // ------------------------------
  // Filler returned by slots with no logic behind them
  localparam logic [31:0] OCL_UNMAPPED_DATA = 32'hDEAD_BEEF;

  // Identity word at slot 5, offset 0
  localparam logic [31:0] OCL_SLOW_ID = 32'hC105_0005;

  // AXI response code, always OKAY
  localparam logic [1:0] OCL_RESP_OKAY = 2'b00;

  // ------------------------------
  // Slow slot timing
  // ------------------------------
  // Cycles from strobe to ack
  localparam int unsigned OCL_SLOW_ACK_DELAY = 3;
  localparam int unsigned OCL_SLOW_CNT_W     = $clog2(OCL_SLOW_ACK_DELAY + 1);

  // Address word, raw or split into slot and byte offset (256B per slot)
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [19:0] unused;
      logic [3:0]  slot;
      logic [7:0]  offset;
    } f;
  } ocl_addr_u;

endpackage

// File: ocl_slv/axil_reg_slice.sv
// AXI-Lite register slice, one holding register per request channel, B and R straight through
`timescale 1ns/1ps

module axil_reg_slice (
  input  logic        clk,
  input  logic        sync_rst_n,
  // Host side
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  // Slave side
  output logic [31:0] awaddr_q,
  output logic        awvalid_q,
  input  logic        awready_q,
  output logic [31:0] wdata_q,
  output logic        wvalid_q,
  input  logic        wready_q,
  input  logic [1:0]  bresp_q,
  input  logic        bvalid_q,
  output logic        bready_q,
  output logic [31:0] araddr_q,
  output logic        arvalid_q,
  input  logic        arready_q,
  input  logic [31:0] rdata_q,
  input  logic [1:0]  rresp_q,
  input  logic        rvalid_q,
  output logic        rready_q
);

  logic       aw_full_nxt;
  logic       w_full_nxt;
  logic       ar_full_nxt;

  // ------------------------------
  // Full flags
  // ------------------------------
  // Fill on host handshake, drain on slave handshake
  always_comb
  begin
    aw_full_nxt = awvalid_q ? !awready_q : (awvalid && awready);
    w_full_nxt  = wvalid_q  ? !wready_q  : (wvalid && wready);
    ar_full_nxt = arvalid_q ? !arready_q : (arvalid && arready);
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      arvalid_q <= 1'b0;
      awready   <= 1'b0;
      wready    <= 1'b0;
      arready   <= 1'b0;
    end
    else
    begin
      awvalid_q <= aw_full_nxt;
      wvalid_q  <= w_full_nxt;
      arvalid_q <= ar_full_nxt;
      // Ready only while the register will be empty
      awready   <= !aw_full_nxt;
      wready    <= !w_full_nxt;
      arready   <= !ar_full_nxt;
    end
  end

  // Payload loads only into an empty register
  always_ff @(posedge clk)
  begin
    if (awvalid && awready)
      awaddr_q <= awaddr;
    if (wvalid && wready)
      wdata_q <= wdata;
    if (arvalid && arready)
      araddr_q <= araddr;
  end

  // Responses are already registered in the FSM
  assign bresp    = bresp_q;
  assign bvalid   = bvalid_q;
  assign bready_q = bready;
  assign rdata    = rdata_q;
  assign rresp    = rresp_q;
  assign rvalid   = rvalid_q;
  assign rready_q = rready;

  // Held beats stay put until taken
  a_aw_held_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (awvalid_q && !awready_q) |=> $stable(awaddr_q))
    else $error("AW slice register changed before handshake");

  a_w_held_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (wvalid_q && !wready_q) |=> $stable(wdata_q))
    else $error("W slice register changed before handshake");

  a_ar_held_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (arvalid_q && !arready_q) |=> $stable(araddr_q))
    else $error("AR slice register changed before handshake");

endmodule

// File: ocl_slv/ocl_slv.sv
// OCL slave FSM with write-first arbitration, slot decode, cfg strobes and AXI responses
`timescale 1ns/1ps

module ocl_slv (
  input  logic                               clk,
  input  logic                               sync_rst_n,
  input  logic                               sh_cl_flr_assert,
  input  logic [31:0]                        awaddr_q,
  input  logic                               awvalid_q,
  output logic                               awready_q,
  input  logic [31:0]                        wdata_q,
  input  logic                               wvalid_q,
  output logic                               wready_q,
  output logic [1:0]                         bresp_q,
  output logic                               bvalid_q,
  input  logic                               bready_q,
  input  logic [31:0]                        araddr_q,
  input  logic                               arvalid_q,
  output logic                               arready_q,
  output logic [31:0]                        rdata_q,
  output logic [1:0]                         rresp_q,
  output logic                               rvalid_q,
  input  logic                               rready_q,
  output logic [31:0]                        cfg_addr,
  output logic [31:0]                        cfg_wdata,
  output logic [ocl_pkg::OCL_NUM_SLOTS-1:0]  cfg_wr,
  output logic [ocl_pkg::OCL_NUM_SLOTS-1:0]  cfg_rd,
  input  logic                               slot0_ack,
  input  logic [31:0]                        slot0_rdata,
  input  logic                               slot5_ack,
  input  logic [31:0]                        slot5_rdata
);
  import ocl_pkg::*;

  typedef enum logic [1:0] {
    SLV_IDLE,
    SLV_WR_ADDR,
    SLV_CYC,
    SLV_RESP
  } slv_state_t;

  slv_state_t  state;
  slv_state_t  state_nxt;
  ocl_addr_u   req_addr;
  logic        cyc_wr;
  logic        did_req;
  logic        req_valid;
  logic        rsp_ready;
  logic        issue;
  logic        slot_ack;
  logic        cyc_done;
  logic [31:0] slot_rdata;
  logic [31:0] rdata_r;

  // Writes also need their data beat
  assign req_valid = cyc_wr ? wvalid_q : 1'b1;
  assign rsp_ready = cyc_wr ? bready_q : rready_q;

  // Latch winner and address, write has fixed priority
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      cyc_wr <= 1'b0;
    else if (state == SLV_IDLE)
      cyc_wr <= awvalid_q;
  end

  always_ff @(posedge clk)
  begin
    if (state == SLV_IDLE)
    begin
      if (awvalid_q)
        req_addr.raw <= awaddr_q;
      else if (arvalid_q)
        req_addr.raw <= araddr_q;
    end
  end

  // ------------------------------
  // Slot decode
  // ------------------------------
  always_comb
  begin
    case (req_addr.f.slot)
      OCL_SLOT_SCRATCH:
      begin
        slot_ack   = did_req && slot0_ack;
        slot_rdata = slot0_rdata;
      end
      OCL_SLOT_SLOW:
      begin
        slot_ack   = did_req && slot5_ack;
        slot_rdata = slot5_rdata;
      end
      default:
      begin
        // Nothing behind it, done at once
        slot_ack   = 1'b1;
        slot_rdata = OCL_UNMAPPED_DATA;
      end
    endcase
  end

  assign cyc_done = req_valid && slot_ack;

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb
  begin
    state_nxt = state;
    if (sh_cl_flr_assert)
      state_nxt = SLV_IDLE;
    else
    begin
      case (state)
        SLV_IDLE:
        begin
          if (awvalid_q)
            state_nxt = SLV_WR_ADDR;
          else if (arvalid_q)
            state_nxt = SLV_CYC;
        end
        SLV_WR_ADDR:
          state_nxt = SLV_CYC;
        SLV_CYC:
        begin
          if (cyc_done)
            state_nxt = SLV_RESP;
        end
        SLV_RESP:
        begin
          if (rsp_ready)
            state_nxt = SLV_IDLE;
        end
        default:
          state_nxt = SLV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      state <= SLV_IDLE;
    else
      state <= state_nxt;
  end

  // One strobe per access
  assign issue = (state == SLV_CYC) && req_valid && !did_req;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      did_req <= 1'b0;
    else if (state == SLV_IDLE)
      did_req <= 1'b0;
    else if (issue)
      did_req <= 1'b1;
  end

  // ------------------------------
  // Config side
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      cfg_wr <= '0;
      cfg_rd <= '0;
    end
    else
    begin
      cfg_wr <= {{(OCL_NUM_SLOTS-1){1'b0}}, issue && cyc_wr} << req_addr.f.slot;
      cfg_rd <= {{(OCL_NUM_SLOTS-1){1'b0}}, issue && !cyc_wr} << req_addr.f.slot;
    end
  end

  // Registered copies for the slots
  always_ff @(posedge clk)
  begin
    cfg_addr  <= req_addr.raw;
    cfg_wdata <= wdata_q;
  end

  // Read data held through RESP
  always_ff @(posedge clk)
  begin
    if ((state == SLV_CYC) && cyc_done)
      rdata_r <= slot_rdata;
  end

  // ------------------------------
  // AXI side
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      arready_q <= 1'b0;
    end
    else
    begin
      awready_q <= (state_nxt == SLV_WR_ADDR);
      // Pop W or AR as the cycle ends, flr included
      wready_q  <= (state == SLV_CYC) && (state_nxt != SLV_CYC) && cyc_wr;
      arready_q <= (state == SLV_CYC) && (state_nxt != SLV_CYC) && !cyc_wr;
    end
  end

  assign bresp_q  = OCL_RESP_OKAY;
  assign bvalid_q = (state == SLV_RESP) && cyc_wr;
  assign rdata_q  = rdata_r;
  assign rresp_q  = OCL_RESP_OKAY;
  assign rvalid_q = (state == SLV_RESP) && !cyc_wr;

  a_strobe_excl: assert property (@(posedge clk) disable iff (!sync_rst_n)
    !((|cfg_wr) && (|cfg_rd)))
    else $error("cfg_wr and cfg_rd together");

  a_resp_excl: assert property (@(posedge clk) disable iff (!sync_rst_n)
    !(bvalid_q && rvalid_q))
    else $error("bvalid and rvalid together");

  // No second strobe until the FSM is back in idle
  a_one_strobe: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (|(cfg_wr | cfg_rd)) |=> ((cfg_wr | cfg_rd) == '0) until (state == SLV_IDLE))
    else $error("more than one strobe in an access");

endmodule

// File: source/scratch_regs.sv
// Slot 0 scratch bank, four read/write registers with a one-cycle ack
`timescale 1ns/1ps

module scratch_regs (
  input  logic        clk,
  input  logic        sync_rst_n,
  input  logic [31:0] cfg_addr,
  input  logic [31:0] cfg_wdata,
  input  logic        cfg_wr,
  input  logic        cfg_rd,
  output logic        cfg_ack,
  output logic [31:0] cfg_rdata
);
  import ocl_pkg::*;

  ocl_addr_u   addr;
  logic [1:0]  idx;
  logic [31:0] regs [4];

  assign addr.raw = cfg_addr;
  // Word index inside the slot
  assign idx = addr.f.offset[3:2];

  // ------------------------------
  // Register bank
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      for (int i = 0; i < 4; i++)
        regs[i] <= '0;
    end
    else if (cfg_wr)
    begin
      regs[idx] <= cfg_wdata;
    end
  end

  // Ack either access on the next cycle
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      cfg_ack <= 1'b0;
    else
      cfg_ack <= cfg_wr || cfg_rd;
  end

  // Read data lines up with the ack
  always_ff @(posedge clk)
  begin
    if (cfg_rd)
      cfg_rdata <= regs[idx];
  end

endmodule

// File: source/slow_regs.sv
// Slot 5 bank, ID word plus two read/write registers, ack after a fixed delay
`timescale 1ns/1ps

module slow_regs (
  input  logic        clk,
  input  logic        sync_rst_n,
  input  logic [31:0] cfg_addr,
  input  logic [31:0] cfg_wdata,
  input  logic        cfg_wr,
  input  logic        cfg_rd,
  output logic        cfg_ack,
  output logic [31:0] cfg_rdata
);
  import ocl_pkg::*;

  ocl_addr_u                 addr;
  logic [1:0]                idx;
  logic [1:0]                idx_h;
  logic [31:0]               reg1;
  logic [31:0]               reg2;
  logic [OCL_SLOW_CNT_W-1:0] cnt;

  assign addr.raw = cfg_addr;
  assign idx      = addr.f.offset[3:2];

  // Writes to index 0 and 3 fall away
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      reg1 <= '0;
      reg2 <= '0;
    end
    else if (cfg_wr)
    begin
      if (idx == 2'd1)
        reg1 <= cfg_wdata;
      else if (idx == 2'd2)
        reg2 <= cfg_wdata;
    end
  end

  // ------------------------------
  // Ack delay
  // ------------------------------
  // Counter reaches 1 the cycle before ack
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      cnt     <= '0;
      cfg_ack <= 1'b0;
    end
    else
    begin
      cfg_ack <= (cnt == OCL_SLOW_CNT_W'(1));
      if (cfg_wr || cfg_rd)
        cnt <= OCL_SLOW_CNT_W'(OCL_SLOW_ACK_DELAY - 1);
      else if (cnt != '0)
        cnt <= cnt - 1'b1;
    end
  end

  // Index held for the read mux at ack time
  always_ff @(posedge clk)
  begin
    if (cfg_wr || cfg_rd)
      idx_h <= idx;
    if (cnt == OCL_SLOW_CNT_W'(1))
    begin
      case (idx_h)
        2'd0:    cfg_rdata <= OCL_SLOW_ID;
        2'd1:    cfg_rdata <= reg1;
        2'd2:    cfg_rdata <= reg2;
        default: cfg_rdata <= '0;
      endcase
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (cfg_wr || cfg_rd) |-> (cnt == '0))
    else $error("slow slot strobed while busy");

endmodule

// File: source/ocl_top.sv
// OCL register slave top level, register slice plus control FSM plus slots 0 and 5
`timescale 1ns/1ps

module ocl_top (
  input  logic        clk,
  input  logic        sync_rst_n,
  input  logic        sh_cl_flr_assert,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);
  import ocl_pkg::*;

  // Sliced AXI-Lite channels
  logic [31:0] awaddr_q;
  logic        awvalid_q;
  logic        awready_q;
  logic [31:0] wdata_q;
  logic        wvalid_q;
  logic        wready_q;
  logic [1:0]  bresp_q;
  logic        bvalid_q;
  logic        bready_q;
  logic [31:0] araddr_q;
  logic        arvalid_q;
  logic        arready_q;
  logic [31:0] rdata_q;
  logic [1:0]  rresp_q;
  logic        rvalid_q;
  logic        rready_q;

  // Config side
  logic [31:0]              cfg_addr;
  logic [31:0]              cfg_wdata;
  logic [OCL_NUM_SLOTS-1:0] cfg_wr;
  logic [OCL_NUM_SLOTS-1:0] cfg_rd;
  logic                     slot0_ack;
  logic [31:0]              slot0_rdata;
  logic                     slot5_ack;
  logic [31:0]              slot5_rdata;

  axil_reg_slice axil_reg_slice_inst (.*);

  ocl_slv ocl_slv_inst (.*);

  scratch_regs scratch_regs_inst (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_wr     (cfg_wr[OCL_SLOT_SCRATCH]),
    .cfg_rd     (cfg_rd[OCL_SLOT_SCRATCH]),
    .cfg_ack    (slot0_ack),
    .cfg_rdata  (slot0_rdata)
  );

  slow_regs slow_regs_inst (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_wr     (cfg_wr[OCL_SLOT_SLOW]),
    .cfg_rd     (cfg_rd[OCL_SLOT_SLOW]),
    .cfg_ack    (slot5_ack),
    .cfg_rdata  (slot5_rdata)
  );

endmodule

// File: verif/ocl_tb.sv
// Testbench for the OCL register slave, AXI-Lite driver tasks, checking assertions and report
`timescale 1ns/1ps

module ocl_tb;

  localparam int          WAIT_LIMIT = 64;
  localparam logic [31:0] ID_WORD    = 32'hC105_0005;
  localparam logic [31:0] FILLER     = 32'hDEAD_BEEF;
  localparam logic [1:0]  RESP_OKAY  = 2'b00;

  logic        clk;
  logic        sync_rst_n;
  logic        sh_cl_flr_assert;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  int          checks;
  int          value_errors;
  int          protocol_errors;
  int          timeouts;
  logic [31:0] rng_state;
  logic        bp_on;
  logic        flr_quiet;
  logic [31:0] scratch_words [4];
  logic [31:0] slow_word1;
  logic [31:0] slow_word2;
  int          unmapped_slots [3] = '{3, 9, 15};

  ocl_top ocl_top_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Ready is random only while back-pressure is on
  function automatic logic pick_ready();
    logic [31:0] r;
    if (!bp_on)
      return 1'b1;
    r = next_random();
    return r[0];
  endfunction

  // 256 bytes per slot, word index in offset bits 3:2
  function automatic logic [31:0] slot_addr(input logic [3:0] slot, input logic [1:0] idx);
    return {20'h0, slot, 4'h0, idx, 2'b00};
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp)
    else
    begin
      value_errors++;
      $display("Fail %s expected %h actual %h", name, exp, got);
    end
  endtask

  // ------------------------------
  // AXI-Lite driver
  // ------------------------------
  task automatic send_read_addr(input logic [31:0] addr, output logic ok);
    int   cyc;
    logic done;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    done = 1'b0;
    cyc  = 0;
    while (!done && cyc < WAIT_LIMIT)
    begin
      @(negedge clk);
      if (arready)
        done = 1'b1;
      @(posedge clk);
      cyc++;
    end
    arvalid <= 1'b0;
    ok = done;
    if (!done)
    begin
      timeouts++;
      $display("Timeout waiting for arready on read of %h", addr);
    end
  endtask

  task automatic axil_read(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic        ok;
    logic        got_resp;
    logic [31:0] got;
    int          cyc;
    send_read_addr(addr, ok);
    if (ok)
    begin
      rready <= pick_ready();
      got_resp = 1'b0;
      cyc      = 0;
      while (!got_resp && cyc < WAIT_LIMIT)
      begin
        @(negedge clk);
        if (rvalid && rready)
        begin
          got_resp = 1'b1;
          got      = rdata;
        end
        @(posedge clk);
        rready <= got_resp ? 1'b0 : pick_ready();
        cyc++;
      end
      if (got_resp)
      begin
        check_word(name, exp, got);
        @(negedge clk);
        assert (!rvalid)
        else
        begin
          protocol_errors++;
          $display("rvalid stayed high after the handshake on %s", name);
        end
      end
      else
      begin
        timeouts++;
        $display("Timeout waiting for rvalid on read of %h", addr);
      end
    end
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    logic aw_done;
    logic w_done;
    logic got_resp;
    int   cyc;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    aw_done = 1'b0;
    w_done  = 1'b0;
    cyc     = 0;
    // AW and W can complete on different edges
    while (!(aw_done && w_done) && cyc < WAIT_LIMIT)
    begin
      @(negedge clk);
      if (awvalid && awready)
        aw_done = 1'b1;
      if (wvalid && wready)
        w_done = 1'b1;
      @(posedge clk);
      if (aw_done)
        awvalid <= 1'b0;
      if (w_done)
        wvalid <= 1'b0;
      cyc++;
    end
    if (!(aw_done && w_done))
    begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      timeouts++;
      $display("Timeout waiting for awready or wready on write to %h", addr);
    end
    else
    begin
      bready <= pick_ready();
      got_resp = 1'b0;
      cyc      = 0;
      while (!got_resp && cyc < WAIT_LIMIT)
      begin
        @(negedge clk);
        if (bvalid && bready)
          got_resp = 1'b1;
        @(posedge clk);
        bready <= got_resp ? 1'b0 : pick_ready();
        cyc++;
      end
      if (got_resp)
      begin
        @(negedge clk);
        assert (!bvalid)
        else
        begin
          protocol_errors++;
          $display("bvalid stayed high after the handshake on write to %h", addr);
        end
      end
      else
      begin
        timeouts++;
        $display("Timeout waiting for bvalid on write to %h", addr);
      end
    end
  endtask

  // ------------------------------
  // Port assertions
  // ------------------------------
  a_resp_excl: assert property (@(posedge clk) disable iff (!sync_rst_n) !(bvalid && rvalid))
    else
    begin
      protocol_errors++;
      $display("bvalid and rvalid were high together at %0t", $time);
    end

  a_bresp_okay: assert property (@(posedge clk) disable iff (!sync_rst_n)
    bvalid |-> (bresp == RESP_OKAY))
    else
    begin
      protocol_errors++;
      $display("Fail bresp expected %0d actual %0d", RESP_OKAY, bresp);
    end

  a_rresp_okay: assert property (@(posedge clk) disable iff (!sync_rst_n)
    rvalid |-> (rresp == RESP_OKAY))
    else
    begin
      protocol_errors++;
      $display("Fail rresp expected %0d actual %0d", RESP_OKAY, rresp);
    end

  // Response held steady under back-pressure
  a_b_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else
    begin
      protocol_errors++;
      $display("Write response changed before bready at %0t", $time);
    end

  a_r_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)))
    else
    begin
      protocol_errors++;
      $display("Read response changed before rready at %0t", $time);
    end

  a_reset_quiet: assert property (@(posedge clk)
    $rose(sync_rst_n) |-> !(awready || wready || arready || bvalid || rvalid))
    else
    begin
      protocol_errors++;
      $display("Handshake outputs were not low right after reset");
    end

  a_flr_quiet: assert property (@(posedge clk) disable iff (!sync_rst_n)
    flr_quiet |-> !(bvalid || rvalid))
    else
    begin
      protocol_errors++;
      $display("A response came out after the function-level reset at %0t", $time);
    end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial
  begin
    logic [1:0]  idx;
    logic [31:0] word;
    logic        ok;
    sync_rst_n       = 1'b0;
    sh_cl_flr_assert = 1'b0;
    awaddr           = '0;
    awvalid          = 1'b0;
    wdata            = '0;
    wstrb            = '0;
    wvalid           = 1'b0;
    bready           = 1'b0;
    araddr           = '0;
    arvalid          = 1'b0;
    rready           = 1'b0;
    checks           = 0;
    value_errors     = 0;
    protocol_errors  = 0;
    timeouts         = 0;
    rng_state        = 32'd77380;
    bp_on            = 1'b0;
    flr_quiet        = 1'b0;
    repeat (3) @(posedge clk);
    sync_rst_n <= 1'b1;

    // Scratch bank in slot 0
    for (int i = 0; i < 4; i++)
    begin
      scratch_words[i] = next_random();
      axil_write(slot_addr(4'd0, 2'(i)), scratch_words[i]);
    end
    for (int i = 0; i < 4; i++)
      axil_read($sformatf("scratch %0d", i), slot_addr(4'd0, 2'(i)), scratch_words[i]);

    // Slow bank in slot 5
    axil_read("slow id", slot_addr(4'd5, 2'd0), ID_WORD);
    axil_write(slot_addr(4'd5, 2'd0), next_random());
    axil_read("slow id after write", slot_addr(4'd5, 2'd0), ID_WORD);
    slow_word1 = next_random();
    slow_word2 = next_random();
    axil_write(slot_addr(4'd5, 2'd1), slow_word1);
    axil_write(slot_addr(4'd5, 2'd2), slow_word2);
    axil_read("slow reg 1", slot_addr(4'd5, 2'd1), slow_word1);
    axil_read("slow reg 2", slot_addr(4'd5, 2'd2), slow_word2);
    axil_read("slow reg 3", slot_addr(4'd5, 2'd3), 32'h0);

    // Unmapped slots
    for (int k = 0; k < 3; k++)
    begin
      axil_write(slot_addr(4'(unmapped_slots[k]), 2'(k)), next_random());
      axil_read($sformatf("unmapped slot %0d", unmapped_slots[k]),
                slot_addr(4'(unmapped_slots[k]), 2'(k)), FILLER);
    end

    // Random back-pressure on B and R
    bp_on = 1'b1;
    for (int n = 0; n < 8; n++)
    begin
      word = next_random();
      idx  = word[5:4];
      scratch_words[idx] = next_random();
      axil_write(slot_addr(4'd0, idx), scratch_words[idx]);
      axil_read($sformatf("scratch %0d under back-pressure", idx),
                slot_addr(4'd0, idx), scratch_words[idx]);
    end
    axil_read("slow reg 1 under back-pressure", slot_addr(4'd5, 2'd1), slow_word1);
    bp_on = 1'b0;

    // Reset the function while slot 5 is still counting
    send_read_addr(slot_addr(4'd5, 2'd1), ok);
    repeat (3) @(posedge clk);
    sh_cl_flr_assert <= 1'b1;
    flr_quiet        <= 1'b1;
    repeat (4) @(posedge clk);
    sh_cl_flr_assert <= 1'b0;
    repeat (12) @(posedge clk);
    flr_quiet <= 1'b0;
    scratch_words[2] = next_random();
    axil_write(slot_addr(4'd0, 2'd2), scratch_words[2]);
    axil_read("scratch 2 after flr", slot_addr(4'd0, 2'd2), scratch_words[2]);

    repeat (4) @(posedge clk);
    $display("checks %0d, value errors %0d, protocol errors %0d, timeouts %0d",
             checks, value_errors, protocol_errors, timeouts);
    if (value_errors + protocol_errors + timeouts == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: compile.f
common/ocl_pkg.sv
ocl_slv/axil_reg_slice.sv
ocl_slv/ocl_slv.sv
source/scratch_regs.sv
source/slow_regs.sv
source/ocl_top.sv
verif/ocl_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module ocl_tb -f compile.f -o ocl_sim &&
out="$(./obj_dir/ocl_sim)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "sim passed" ||
exit 1
